// ==== project.f ====
rhPkg.sv
rhWordCount.sv
rhBusAddr.sv
rhCsr.sv
rhDmaEngine.sv
rhAxiSlave.sv
rhController.sv
tbRhController.sv

// ==== rhAxiSlave.sv ====
//////////////////////////////
// AXI4-Lite register slave
//  Write and read handshakes
//  Offset decode into regWr, readback mux
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rhAxiSlave (
   input  logic          clk,
   input  logic          rst,
   input  logic          awvalid,
   output logic          awready,
   input  logic [3:0]    awaddr,
   input  logic          wvalid,
   output logic          wready,
   input  logic [31:0]   wdata,
   input  logic [3:0]    wstrb,
   output logic          bvalid,
   input  logic          bready,
   output logic [1:0]    bresp,
   input  logic          arvalid,
   output logic          arready,
   input  logic [3:0]    araddr,
   output logic          rvalid,
   input  logic          rready,
   output logic [31:0]   rdata,
   output logic [1:0]    rresp,
   output rhPkg::regWr_t regWr,
   input  logic [15:0]   csrOut,
   input  logic [15:0]   wc,
   input  logic [15:0]   ba
);

   import rhPkg::*;

   logic        wrAccept;
   logic        rdAccept;
   logic [15:0] rdMux;

   ////////////////////////////////
   // Write channel
   ////////////////////////////////

   // Address and data together, one write outstanding
   assign wrAccept = awvalid && wvalid && !bvalid;
   assign awready  = wrAccept;
   assign wready   = wrAccept;
   assign bresp    = 2'b00;

   always_ff @(posedge clk)
   begin
      if (rst)
         bvalid <= 1'b0;
      else if (wrAccept)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
   end

   // Strobe bits 0 and 1 pick the byte lanes
   always_comb
   begin
      regWr = '0;
      regWr.sel[SEL_CS1] = wrAccept && (awaddr == CS1_OFS);
      regWr.sel[SEL_WC]  = wrAccept && (awaddr == WC_OFS);
      regWr.sel[SEL_BA]  = wrAccept && (awaddr == BA_OFS);
      regWr.lo   = wstrb[0];
      regWr.hi   = wstrb[1];
      regWr.data = wdata[15:0];
   end

   ////////////////////////////////
   // Read channel
   ////////////////////////////////

   assign arready  = !rvalid;
   assign rdAccept = arvalid && arready;
   assign rresp    = 2'b00;

   // Unmapped offsets read zero
   always_comb
   begin
      case (araddr)
         CS1_OFS: rdMux = csrOut;
         WC_OFS:  rdMux = wc;
         BA_OFS:  rdMux = ba;
         default: rdMux = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         rvalid <= 1'b0;
      else if (rdAccept)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   // Read data captured at acceptance
   always_ff @(posedge clk)
   begin
      if (rdAccept)
         rdata <= {16'h0000, rdMux};
   end

endmodule

`default_nettype wire

// ==== rhBusAddr.sv ====
//////////////////////////////
// Bus address register
//  Even memory address, byte-lane loads
//  Clear and increment by two per word
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rhBusAddr #(
   parameter int ADDR_W = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  rhPkg::regWr_t     regWr,
   input  logic              ctrlClr,
   input  logic              step,
   output logic [ADDR_W-1:0] ba
);

   import rhPkg::*;

   logic [15:0] baLoad;

   // Merge enabled lanes over the current low half
   always_comb
   begin
      baLoad = ba[15:0];
      if (regWr.hi)
         baLoad[15:8] = regWr.data[15:8];
      if (regWr.lo)
         baLoad[7:0] = {regWr.data[7:1], 1'b0};
   end

   always_ff @(posedge clk)
   begin
      if (rst || ctrlClr)
         ba <= '0;
      else if (regWr.sel[SEL_BA])
         // Upper bits beyond 16 load as zero
         ba <= ADDR_W'(baLoad);
      else if (step)
         ba <= ba + ADDR_W'(2);
   end

   // Word addressing only, bit 0 never set
   assert property (@(posedge clk) disable iff (rst) ba[0] == 1'b0)
      else $error("Bus address went odd");

endmodule

`default_nettype wire

// ==== rhController.sv ====
//////////////////////////////
// DMA controller top level
//  Host slave, CS1, WC, BA and engine
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rhController #(
   parameter int ADDR_W = 16
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            awvalid,
   output logic            awready,
   input  logic [3:0]      awaddr,
   input  logic            wvalid,
   output logic            wready,
   input  logic [31:0]     wdata,
   input  logic [3:0]      wstrb,
   output logic            bvalid,
   input  logic            bready,
   output logic [1:0]      bresp,
   input  logic            arvalid,
   output logic            arready,
   input  logic [3:0]      araddr,
   output logic            rvalid,
   input  logic            rready,
   output logic [31:0]     rdata,
   output logic [1:0]      rresp,
   output logic            memReqValid,
   input  logic            memReqReady,
   output rhPkg::memReq_t  memReq,
   input  logic            memRspValid,
   input  rhPkg::memRsp_t  memRsp,
   output logic            drvOutValid,
   input  logic            drvOutReady,
   output rhPkg::drvWord_t drvOut,
   input  logic            drvInValid,
   output logic            drvInReady,
   input  rhPkg::drvWord_t drvIn
);

   import rhPkg::*;

   regWr_t            regWr;
   logic [15:0]       csrOut;
   logic [15:0]       wc;
   logic [ADDR_W-1:0] ba;
   logic              start;
   rhFunc_t           func;
   logic              ctrlClr;
   logic              xferDone;
   logic              step;

   // Host side
   rhAxiSlave rhAxiSlave_i (
      .clk(clk), .rst(rst),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
      .regWr(regWr), .csrOut(csrOut), .wc(wc), .ba(ba[15:0])
   );

   rhCsr rhCsr_i (
      .clk(clk), .rst(rst), .regWr(regWr), .xferDone(xferDone),
      .start(start), .func(func), .ctrlClr(ctrlClr), .csrOut(csrOut)
   );

   rhWordCount rhWordCount_i (
      .clk(clk), .rst(rst), .regWr(regWr), .ctrlClr(ctrlClr),
      .step(step), .wc(wc)
   );

   rhBusAddr #(.ADDR_W(ADDR_W)) rhBusAddr_i (
      .clk(clk), .rst(rst), .regWr(regWr), .ctrlClr(ctrlClr),
      .step(step), .ba(ba)
   );

   // Memory and drive side
   rhDmaEngine #(.ADDR_W(ADDR_W)) rhDmaEngine_i (
      .clk(clk), .rst(rst), .start(start), .func(func), .ctrlClr(ctrlClr),
      .wc(wc), .ba(ba), .step(step), .xferDone(xferDone),
      .memReqValid(memReqValid), .memReqReady(memReqReady), .memReq(memReq),
      .memRspValid(memRspValid), .memRsp(memRsp),
      .drvOutValid(drvOutValid), .drvOutReady(drvOutReady), .drvOut(drvOut),
      .drvInValid(drvInValid), .drvInReady(drvInReady), .drvIn(drvIn)
   );

endmodule

`default_nettype wire

// ==== rhCsr.sv ====
//////////////////////////////
// Control/status register CS1
//  Function code and ready bit
//  GO start pulse, controller clear
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rhCsr (
   input  logic           clk,
   input  logic           rst,
   input  rhPkg::regWr_t  regWr,
   input  logic           xferDone,
   output logic           start,
   output rhPkg::rhFunc_t func,
   output logic           ctrlClr,
   output logic [15:0]    csrOut
);

   import rhPkg::*;

   logic rdy;
   logic csrWrLo;
   logic goWr;

   // GO, function and CLR all live in the low byte
   assign csrWrLo = regWr.sel[SEL_CS1] && regWr.lo;
   assign goWr = csrWrLo && regWr.data[CS1_GO] && !regWr.data[CS1_CLR];

   // Clear pulse straight from the write so it lands with the register update
   assign ctrlClr = csrWrLo && regWr.data[CS1_CLR];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rdy   <= 1'b1;
         func  <= NOP;
         start <= 1'b0;
      end
      else
      begin
         // GO only counts while idle
         start <= goWr && rdy;
         if (ctrlClr)
            rdy <= 1'b1;
         else if (goWr && rdy)
            rdy <= 1'b0;
         else if (xferDone)
            rdy <= 1'b1;
         // Function code frozen while a transfer runs
         if (csrWrLo && rdy)
            func <= rhFunc_t'(regWr.data[CS1_FUNC_MSB:CS1_FUNC_LSB]);
      end
   end

   ////////////////////////////////
   // Readback
   ////////////////////////////////

   // GO reads as busy, CLR always reads zero
   always_comb
   begin
      csrOut = '0;
      csrOut[CS1_GO] = !rdy;
      csrOut[CS1_FUNC_MSB:CS1_FUNC_LSB] = func;
      csrOut[CS1_RDY] = rdy;
   end

   // Engine only finishes what GO started
   assert property (@(posedge clk) disable iff (rst) xferDone |-> !rdy)
      else $error("Transfer done while controller ready");

endmodule

`default_nettype wire

// ==== rhDmaEngine.sv ====
//////////////////////////////
// Transfer engine
//  WRITE moves memory to drive, READ drive to memory
//  One word in flight, steps WC and BA per word
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rhDmaEngine #(
   parameter int ADDR_W = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              start,
   input  rhPkg::rhFunc_t    func,
   input  logic              ctrlClr,
   input  logic [15:0]       wc,
   input  logic [ADDR_W-1:0] ba,
   output logic              step,
   output logic              xferDone,
   output logic              memReqValid,
   input  logic              memReqReady,
   output rhPkg::memReq_t    memReq,
   input  logic              memRspValid,
   input  rhPkg::memRsp_t    memRsp,
   output logic              drvOutValid,
   input  logic              drvOutReady,
   output rhPkg::drvWord_t   drvOut,
   input  logic              drvInValid,
   output logic              drvInReady,
   input  rhPkg::drvWord_t   drvIn
);

   import rhPkg::*;

   rhState_t    state;
   logic        reqSent;
   logic [15:0] dataReg;
   logic        isWrite;
   logic        isRead;
   logic        lastWord;
   logic        rspTake;

   assign isWrite = (func == WRITE);
   assign isRead  = (func == READ);

   // Next step clears WC, or WC was zero at start and only one word goes
   assign lastWord = (wc[15:1] == 15'h7fff) || (wc == 16'h0000);

   ////////////////////////////////
   // Port outputs
   ////////////////////////////////

   // WRITE drops the request once accepted and waits for read data
   assign memReqValid  = (state == MEMREQ) && !(isWrite && reqSent);
   assign memReq.addr  = MEM_ADDR_MAX'(ba);
   assign memReq.we    = isRead;
   assign memReq.wdata = dataReg;
   assign drvOutValid  = (state == DRVXFER) && isWrite;
   assign drvOut       = dataReg;
   assign drvInReady   = (state == DRVXFER) && isRead;

   // Read data may come back in the acceptance cycle or later
   assign rspTake = (state == MEMREQ) && isWrite && memRspValid && (reqSent || memReqReady);

   // One step per completed word
   assign step = (drvOutValid && drvOutReady) || (isRead && memReqValid && memReqReady);

   always_ff @(posedge clk)
   begin
      if (rst || ctrlClr)
      begin
         state    <= IDLE;
         reqSent  <= 1'b0;
         xferDone <= 1'b0;
      end
      else
      begin
         xferDone <= (state == DONE);
         case (state)
            IDLE:
               if (start)
               begin
                  if (isWrite)
                     state <= MEMREQ;
                  else if (isRead)
                     state <= DRVXFER;
                  else
                     state <= DONE;
               end
            MEMREQ:
               if (rspTake)
               begin
                  state   <= DRVXFER;
                  reqSent <= 1'b0;
               end
               else if (isWrite && memReqValid && memReqReady)
                  reqSent <= 1'b1;
               else if (isRead && memReqReady)
                  state <= lastWord ? DONE : DRVXFER;
            DRVXFER:
               if (drvOutValid && drvOutReady)
                  state <= lastWord ? DONE : MEMREQ;
               else if (drvInReady && drvInValid)
                  state <= MEMREQ;
            DONE:
               state <= IDLE;
            default:
               state <= IDLE;
         endcase
      end
   end

   // Word held between the two phases
   always_ff @(posedge clk)
   begin
      if (rspTake)
         dataReg <= memRsp.rdata;
      else if (drvInReady && drvInValid)
         dataReg <= drvIn;
   end

   // Request held steady until memory takes it
   assert property (@(posedge clk) disable iff (rst)
      memReqValid && !memReqReady && !ctrlClr |=> memReqValid && $stable(memReq))
      else $error("Memory request changed before acceptance");

endmodule

`default_nettype wire

// ==== rhPkg.sv ====
//////////////////////////////
// Shared definitions for the RH11-style DMA controller
//  Register offsets and CS1 bit positions
//  Function code and transfer state enums
//  Register write, memory and drive port types
//////////////////////////////

`default_nettype none

package rhPkg;

   // Register byte offsets on the host port
   localparam logic [3:0] CS1_OFS = 4'h0;
   localparam logic [3:0] WC_OFS  = 4'h4;
   localparam logic [3:0] BA_OFS  = 4'h8;

   // One-hot positions inside regWr_t.sel
   localparam int SEL_CS1 = 0;
   localparam int SEL_WC  = 1;
   localparam int SEL_BA  = 2;

   // CS1 bit positions
   localparam int CS1_GO       = 0;
   localparam int CS1_FUNC_LSB = 1;
   localparam int CS1_FUNC_MSB = 5;
   localparam int CS1_CLR      = 6;
   localparam int CS1_RDY      = 7;

   // Address field width of the memory port, ADDR_W bits of it are used
   localparam int MEM_ADDR_MAX = 24;

   typedef enum logic [4:0] {
      NOP   = 5'h00,
      WRITE = 5'h18,
      READ  = 5'h1C
   } rhFunc_t;

   typedef enum logic [1:0] {
      IDLE,
      MEMREQ,
      DRVXFER,
      DONE
   } rhState_t;

   // One-cycle register write from the host port
   typedef struct packed {
      logic [2:0]  sel;
      logic        hi;
      logic        lo;
      logic [15:0] data;
   } regWr_t;

   typedef struct packed {
      logic [MEM_ADDR_MAX-1:0] addr;
      logic                    we;
      logic [15:0]             wdata;
   } memReq_t;

   typedef struct packed {
      logic [15:0] rdata;
   } memRsp_t;

   typedef logic [15:0] drvWord_t;

endpackage

`default_nettype wire

// ==== rhWordCount.sv ====
//////////////////////////////
// Word count register
//  Negative byte count, byte-lane loads
//  Clear and increment by two per word
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rhWordCount (
   input  logic           clk,
   input  logic           rst,
   input  rhPkg::regWr_t  regWr,
   input  logic           ctrlClr,
   input  logic           step,
   output logic [15:0]    wc
);

   import rhPkg::*;

   logic wcWrite;

   // Host write aimed at this register
   assign wcWrite = regWr.sel[SEL_WC];

   always_ff @(posedge clk)
   begin
      if (rst || ctrlClr)
         wc <= '0;
      else if (wcWrite)
      begin
         // Each byte lane loads on its own
         if (regWr.hi)
            wc[15:8] <= regWr.data[15:8];
         if (regWr.lo)
            wc[7:0] <= regWr.data[7:0];
      end
      else if (step)
         // One word is two bytes
         wc <= wc + 16'd2;
   end

   // Host must leave WC alone while the engine is counting
   assert property (@(posedge clk) disable iff (rst) !(wcWrite && step))
      else $error("WC written in the same cycle as a transfer step");

endmodule

`default_nettype wire

// ==== tbRhController.sv ====
//////////////////////////////
// Testbench for the DMA controller
//  Table of register and transfer tests
//  Memory and drive port models with random stalls
//  Typed compare tasks and a watchdog
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tbRhController;

   import rhPkg::*;

   localparam int ADDR_W    = 16;
   localparam int MEM_WORDS = 64;
   localparam int NUM_TESTS = 11;

   // Register contents before each strobe test
   localparam logic [15:0] PRESET = 16'hA5C3;

   // AXI OKAY response
   localparam logic [1:0] RESP_OKAY = 2'b00;

   typedef enum {KIND_REGS, KIND_XFER, KIND_CLEAR} testKind_t;

   typedef struct {
      string       name;
      testKind_t   kind;
      rhFunc_t     func;
      int          words;
      logic [15:0] wcVal;
      logic [15:0] baVal;
      logic [3:0]  strb;
      logic [15:0] expWc;
      logic [15:0] expBa;
   } testRow_t;

   // Name, kind, function, words, WC, BA, strobes, expected WC and BA
   testRow_t tests [NUM_TESTS] = '{
      '{"regsNone", KIND_REGS, NOP, 0, 16'h1234, 16'h5679, 4'h0, 16'hA5C3, 16'hA5C2},
      '{"regsLo", KIND_REGS, NOP, 0, 16'h1234, 16'h5679, 4'h1, 16'hA534, 16'hA578},
      '{"regsHi", KIND_REGS, NOP, 0, 16'h1234, 16'h5679, 4'h2, 16'h12C3, 16'h56C2},
      '{"regsBoth", KIND_REGS, NOP, 0, 16'h1234, 16'h5679, 4'h3, 16'h1234, 16'h5678},
      '{"nopGo", KIND_XFER, NOP, 0, 16'hFFF8, 16'h0010, 4'h3, 16'hFFF8, 16'h0010},
      '{"writeEight", KIND_XFER, WRITE, 8, 16'hFFF0, 16'h0008, 4'h3, 16'h0000, 16'h0018},
      '{"readEight", KIND_XFER, READ, 8, 16'hFFF0, 16'h0020, 4'h3, 16'h0000, 16'h0030},
      '{"writeOne", KIND_XFER, WRITE, 1, 16'hFFFE, 16'h003E, 4'h3, 16'h0000, 16'h0040},
      '{"writeWcZero", KIND_XFER, WRITE, 1, 16'h0000, 16'h0050, 4'h3, 16'h0002, 16'h0052},
      '{"readTail", KIND_XFER, READ, 3, 16'hFFFA, 16'h007A, 4'h3, 16'h0000, 16'h0080},
      '{"clearStalled", KIND_CLEAR, WRITE, 8, 16'hFFF0, 16'h0010, 4'h3, 16'h0000, 16'h0000}
   };

   // DUT inputs start at known values
   logic        clk = 1'b0;
   logic        rst = 1'b1;
   logic        awvalid = 1'b0;
   logic        awready;
   logic [3:0]  awaddr = '0;
   logic        wvalid = 1'b0;
   logic        wready;
   logic [31:0] wdata = '0;
   logic [3:0]  wstrb = '0;
   logic        bvalid;
   logic        bready = 1'b0;
   logic [1:0]  bresp;
   logic        arvalid = 1'b0;
   logic        arready;
   logic [3:0]  araddr = '0;
   logic        rvalid;
   logic        rready = 1'b0;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        memReqValid;
   logic        memReqReady = 1'b0;
   memReq_t     memReq;
   logic        memRspValid = 1'b0;
   memRsp_t     memRsp = '0;
   logic        drvOutValid;
   logic        drvOutReady = 1'b0;
   drvWord_t    drvOut;
   logic        drvInValid = 1'b0;
   logic        drvInReady;
   drvWord_t    drvIn = '0;

   // Port model state
   logic [31:0] lcgState = 32'h3602_c627;
   drvWord_t    mem [MEM_WORDS];
   drvWord_t    memBefore [MEM_WORDS];
   drvWord_t    drvRecv [$];
   drvWord_t    drvSent [$];
   int          memAccepts = 0;
   logic        holdDrvOut = 1'b0;
   logic        rspPending = 1'b0;
   int          rspDelay = 0;
   int          rspIndex = 0;

   // Result counters
   int errors = 0;
   int testErrors = 0;
   int failedTests = 0;
   int testsRun = 0;

   // Test that the host port tasks report against
   string curTest = "reset";

   rhController #(.ADDR_W(ADDR_W)) rhController_i (
      .clk(clk), .rst(rst),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
      .memReqValid(memReqValid), .memReqReady(memReqReady), .memReq(memReq),
      .memRspValid(memRspValid), .memRsp(memRsp),
      .drvOutValid(drvOutValid), .drvOutReady(drvOutReady), .drvOut(drvOut),
      .drvInValid(drvInValid), .drvInReady(drvInReady), .drvIn(drvIn)
   );

   // 100 ns clock
   initial
   begin
      forever
      begin
         #50 clk = ~clk;
      end
   end

   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   ////////////////////////////////
   // Memory and drive models
   ////////////////////////////////

   always @(posedge clk)
   begin
      logic [31:0] r;
      r = nextRandom();
      // Read data pulse after a random delay
      memRspValid <= 1'b0;
      if (rspPending)
      begin
         if (rspDelay == 0)
         begin
            memRspValid  <= 1'b1;
            memRsp.rdata <= mem[rspIndex];
            rspPending = 1'b0;
         end
         else
            rspDelay = rspDelay - 1;
      end
      if (memReqValid && memReqReady)
      begin
         memAccepts = memAccepts + 1;
         if (memReq.we)
            mem[memReq.addr[6:1]] = memReq.wdata;
         else
         begin
            rspPending = 1'b1;
            rspDelay = int'(r[9:8]) % 3;
            rspIndex = int'(memReq.addr[6:1]);
         end
      end
      memReqReady <= r[2] | r[3];
      // Drive sink, stalled on request
      if (drvOutValid && drvOutReady)
         drvRecv.push_back(drvOut);
      drvOutReady <= holdDrvOut ? 1'b0 : (r[4] | r[5]);
      // Drive source holds each word until taken
      if (drvInValid && drvInReady)
      begin
         drvSent.push_back(drvIn);
         drvInValid <= 1'b0;
      end
      else if (!drvInValid && (r[6] | r[7]))
      begin
         drvInValid <= 1'b1;
         drvIn      <= r[31:16];
      end
   end

   ////////////////////////////////
   // Host port tasks
   ////////////////////////////////

   task automatic axiWrite(input logic [3:0] addr, input logic [15:0] data,
                           input logic [3:0] strb);
      @(posedge clk);
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      awaddr  <= addr;
      wdata   <= {16'h0000, data};
      wstrb   <= strb;
      // Address and data taken together
      @(posedge clk);
      while (!awready)
         @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b1;
      @(posedge clk);
      while (!bvalid)
         @(posedge clk);
      checkResp(curTest, "BRESP", RESP_OKAY, bresp);
      bready <= 1'b0;
   endtask

   task automatic axiRead(input logic [3:0] addr, output logic [15:0] data);
      @(posedge clk);
      arvalid <= 1'b1;
      araddr  <= addr;
      @(posedge clk);
      while (!arready)
         @(posedge clk);
      arvalid <= 1'b0;
      rready  <= 1'b1;
      @(posedge clk);
      while (!rvalid)
         @(posedge clk);
      data = rdata[15:0];
      // Registers are 16 bits wide, upper half of the bus reads zero
      checkReg16(curTest, "RDATA upper half", 16'h0000, rdata[31:16]);
      checkResp(curTest, "RRESP", RESP_OKAY, rresp);
      rready <= 1'b0;
   endtask

   ////////////////////////////////
   // Compare tasks
   ////////////////////////////////

   task automatic noteError();
      errors = errors + 1;
      testErrors = testErrors + 1;
   endtask

   task automatic checkReg16(input string testName, input string what,
                             input logic [15:0] expected, input logic [15:0] actual);
      if (actual !== expected)
      begin
         $display("Error %s %s: expected %h, actual %h", testName, what, expected, actual);
         noteError();
      end
   endtask

   task automatic checkWord(input string testName, input int index,
                            input drvWord_t expected, input drvWord_t actual);
      if (actual !== expected)
      begin
         $display("Error %s word %0d: expected %h, actual %h", testName, index, expected,
                  actual);
         noteError();
      end
   endtask

   task automatic checkResp(input string testName, input string what,
                            input logic [1:0] expected, input logic [1:0] actual);
      if (actual !== expected)
      begin
         $display("Error %s %s: expected %b, actual %b", testName, what, expected, actual);
         noteError();
      end
   endtask

   task automatic checkCount(input string testName, input string what,
                             input int expected, input int actual);
      if (actual != expected)
      begin
         $display("Error %s %s: expected %0d, actual %0d", testName, what, expected, actual);
         noteError();
      end
   endtask

   task automatic checkRegs(input testRow_t row);
      logic [15:0] value;
      axiRead(WC_OFS, value);
      checkReg16(row.name, "WC", row.expWc, value);
      axiRead(BA_OFS, value);
      checkReg16(row.name, "BA", row.expBa, value);
   endtask

   // Poll CS1 until RDY comes back
   task automatic waitReady(input string testName, output logic [15:0] csr);
      int polls;
      polls = 0;
      axiRead(CS1_OFS, csr);
      while (!csr[CS1_RDY] && polls < 500)
      begin
         axiRead(CS1_OFS, csr);
         polls++;
      end
      if (!csr[CS1_RDY])
      begin
         $display("%s: controller never returned to ready", testName);
         noteError();
      end
   endtask

   task automatic reportTest(input string testName);
      testsRun++;
      if (testErrors == 0)
         $display("%-14s ok", testName);
      else
      begin
         failedTests++;
         $display("%-14s failed with %0d errors", testName, testErrors);
      end
      testErrors = 0;
   endtask

   ////////////////////////////////
   // Test kinds
   ////////////////////////////////

   // Only the enabled byte lanes may change
   task automatic runRegs(input testRow_t row);
      axiWrite(WC_OFS, PRESET, 4'h3);
      axiWrite(BA_OFS, PRESET, 4'h3);
      axiWrite(WC_OFS, row.wcVal, row.strb);
      axiWrite(BA_OFS, row.baVal, row.strb);
      checkRegs(row);
   endtask

   task automatic runXfer(input testRow_t row);
      logic [15:0] csr;
      drvWord_t    expected;
      int          memBase;
      int          recvBase;
      int          sentBase;
      int          first;
      int          i;
      axiWrite(WC_OFS, row.wcVal, 4'h3);
      axiWrite(BA_OFS, row.baVal, 4'h3);
      memBefore = mem;
      memBase  = memAccepts;
      recvBase = drvRecv.size();
      sentBase = drvSent.size();
      first    = int'(row.baVal[6:1]);
      // Function plus GO in the low byte
      axiWrite(CS1_OFS, {10'h000, row.func, 1'b1}, 4'h1);
      waitReady(row.name, csr);
      checkReg16(row.name, "CS1", {8'h00, 1'b1, 1'b0, row.func, 1'b0}, csr);
      checkRegs(row);
      checkCount(row.name, "memory transfers", row.words, memAccepts - memBase);
      if (row.func == WRITE)
      begin
         checkCount(row.name, "drive words out", row.words, drvRecv.size() - recvBase);
         for (i = 0; i < row.words && recvBase + i < drvRecv.size(); i++)
            checkWord(row.name, i, mem[first + i], drvRecv[recvBase + i]);
      end
      else if (row.func == READ)
      begin
         checkCount(row.name, "drive words in", row.words, drvSent.size() - sentBase);
         // Whole memory, untouched words included
         for (i = 0; i < MEM_WORDS; i++)
         begin
            expected = memBefore[i];
            if (i >= first && i < first + row.words && sentBase + i - first < drvSent.size())
               expected = drvSent[sentBase + i - first];
            checkWord(row.name, i, expected, mem[i]);
         end
      end
      else
         checkCount(row.name, "drive words", 0,
                    (drvRecv.size() - recvBase) + (drvSent.size() - sentBase));
   endtask

   // Clear while the drive side holds the engine stalled
   task automatic runClear(input testRow_t row);
      logic [15:0] csr;
      int          memBase;
      int          recvBase;
      int          sentBase;
      int          waits;
      holdDrvOut = 1'b1;
      axiWrite(WC_OFS, row.wcVal, 4'h3);
      axiWrite(BA_OFS, row.baVal, 4'h3);
      axiWrite(CS1_OFS, {10'h000, row.func, 1'b1}, 4'h1);
      waits = 0;
      while (!drvOutValid && waits < 200)
      begin
         @(posedge clk);
         waits++;
      end
      if (!drvOutValid)
      begin
         $display("%s: engine never offered a drive word", row.name);
         noteError();
      end
      memBase  = memAccepts;
      recvBase = drvRecv.size();
      sentBase = drvSent.size();
      axiWrite(CS1_OFS, 16'h0040, 4'h1);
      holdDrvOut = 1'b0;
      // Quiet window with the drive side free again
      repeat (20) @(posedge clk);
      axiRead(CS1_OFS, csr);
      checkReg16(row.name, "CS1", {8'h00, 1'b1, 1'b0, row.func, 1'b0}, csr);
      checkRegs(row);
      checkCount(row.name, "port transfers after clear", 0,
                 (memAccepts - memBase) + (drvRecv.size() - recvBase) +
                 (drvSent.size() - sentBase));
   endtask

   ////////////////////////////////
   // Main sequence
   ////////////////////////////////

   initial
   begin
      logic [31:0] r;
      logic [15:0] value;
      int          i;
      for (i = 0; i < MEM_WORDS; i++)
      begin
         r = nextRandom();
         mem[i] = r[31:16];
      end
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      // Idle ports and ready controller after reset
      checkReg16("reset", "port valids", 16'h0000,
                 {11'h000, memReqValid, drvOutValid, drvInReady, bvalid, rvalid});
      axiRead(CS1_OFS, value);
      checkReg16("reset", "CS1", 16'h0080, value);
      axiRead(WC_OFS, value);
      checkReg16("reset", "WC", 16'h0000, value);
      axiRead(BA_OFS, value);
      checkReg16("reset", "BA", 16'h0000, value);
      reportTest("reset");
      for (i = 0; i < NUM_TESTS; i++)
      begin
         curTest = tests[i].name;
         case (tests[i].kind)
            KIND_REGS:
               runRegs(tests[i]);
            KIND_XFER:
               runXfer(tests[i]);
            default:
               runClear(tests[i]);
         endcase
         reportTest(tests[i].name);
      end
      $display("%0d tests, %0d failed, %0d errors", testsRun, failedTests, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // Limit scales with the words the table moves
   initial
   begin
      int limit;
      int i;
      limit = 2000;
      for (i = 0; i < NUM_TESTS; i++)
         limit = limit + tests[i].words * 40;
      repeat (limit) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run stopped", limit);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire
